// File: dsp_ctrl.f
hw/dsp_ctrl_pkg.sv
hw/load_route.sv
hw/irq_unit.sv
hw/do_loop_unit.sv
hw/insn_decoder.sv
hw/dsp_ctrl_top.sv
testbench/tb_dsp_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the DSP control unit testbench with Verilator, run it, check for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_dsp_ctrl -o tb_dsp_ctrl -f dsp_ctrl.f || exit 1
out=$(./obj_dir/tb_dsp_ctrl)
echo "$out"
echo "$out" | grep -q "Result: PASSED" && echo "simulation passed" && exit 0 ||
    { echo "simulation failed"; exit 1; }

// File: testbench/tb_dsp_ctrl.sv
/* Testbench for the DSP instruction control unit
   Clock, reset, instruction word stimulus, assertion checks and watchdog */
`timescale 1ns/1ps

module tb_dsp_ctrl;
    import dsp_ctrl_pkg::*;

    localparam int clk_period = 4;
    localparam int n_short    = 8;
    localparam int n_load     = 12;
    localparam int n_jump     = 6;
    localparam int test_words = 2 * n_short + 3 * n_load + 4 * n_jump + 40;
    localparam logic [15:0] filler    = 16'h3000;   // F1 with Y read, one cycle
    localparam logic [15:0] bad_word  = 16'h2000;   // T code 4, faults if decoded
    localparam logic [15:0] iret_word = 16'hc100;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        irq;
    logic        con_result;
    logic [15:0] rom_dout;
    logic        goto_ja, goto_b, call_ja, pc_halt, con_check, irq_start, iack, fault;
    logic [2:0]  r_field;
    logic [1:0]  y_field, inc_sel, a_field;
    logic [8:0]  short_imm;
    logic [15:0] long_imm;
    logic        step_sel, dau_dec_en, ram_we, post_load;
    logic        short_load, long_load, ram_load, xaau_imm_load, xaau_ram_load;
    logic        dau_imm_load, dau_ram_load, sio_imm_load, sio_ram_load;
    logic        pio_imm_load, pio_ram_load;
    logic        do_start, do_out, do_redo, do_save, do_short;
    logic [3:0]  do_pc;

    int          errors;
    int          words;
    int          n_out;
    int          n_save;
    logic        chk_idle, chk_short, chk_route, chk_long, chk_jump, chk_irq, chk_iack;
    logic        chk_fault;
    logic        chk_step;
    logic        fault_ok;   // Set once a fault is provoked on purpose
    logic [8:0]  exp_imm;
    logic [2:0]  exp_r;
    logic [10:0] exp_route;
    logic [15:0] exp_long;
    logic        exp_ja, exp_b, exp_irq_start, exp_iack;
    logic        exp_step;
    logic [3:0]  exp_ni;
    logic [10:0] strobes;
    logic [15:0] ctrl_bits;

    assign strobes = {short_load, long_load, ram_load, xaau_imm_load, xaau_ram_load,
                      dau_imm_load, dau_ram_load, sio_imm_load, sio_ram_load,
                      pio_imm_load, pio_ram_load};
    assign ctrl_bits = {goto_ja, goto_b, call_ja, pc_halt, con_check, irq_start, iack,
                        fault, dau_dec_en, ram_we, post_load, do_start, do_out, do_redo,
                        do_save, do_short};

    dsp_ctrl_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * 40 * test_words);
        $display("timeout: the test sequence did not complete, %0d errors so far", errors);
        $display("Result: FAILED");
        $finish;
    end

    // Loop pulses counted away from the clock edge
    always @(negedge clk) begin
        if (!rst && do_out)
            n_out++;
        if (!rst && do_save)
            n_save++;
    end

    task automatic report(input string name, input logic [15:0] expv, input logic [15:0] got);
        errors++;
        $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, expv, got);
    endtask

    task automatic clear_checks();
        chk_idle  = 1'b0;
        chk_short = 1'b0;
        chk_route = 1'b0;
        chk_long  = 1'b0;
        chk_jump  = 1'b0;
        chk_irq   = 1'b0;
        chk_iack  = 1'b0;
        chk_fault = 1'b0;
        chk_step  = 1'b0;
    endtask

    task automatic send_word(input logic [15:0] w);
        @(posedge clk);
        #1;
        rom_dout = w;
        words++;
        clear_checks();
    endtask

    // Strobe order follows the strobes vector, short_load is bit 10
    function automatic logic [10:0] expected_strobes(input logic ram, input logic [2:0] code,
                                                     input logic pio);
        logic [10:0] v;
        v = '0;
        case (code)
            3'd0:    v[ram ? 8 : 9] = 1'b1;   // YAAU
            3'd1:    v[ram ? 6 : 7] = 1'b1;
            3'd2:    v[ram ? 4 : 5] = 1'b1;
            3'd3:    v[pio ? (ram ? 0 : 1) : (ram ? 2 : 3)] = 1'b1;
            default: ;                        // No register selected
        endcase
        return v;
    endfunction

    idle_ctrl: assert property (@(posedge clk) disable iff (rst) chk_idle |-> ctrl_bits == '0)
        else report("control outputs", 16'h0, $sampled(ctrl_bits));
    idle_strobes: assert property (@(posedge clk) disable iff (rst) chk_idle |-> strobes == '0)
        else report("load strobes", 16'h0, 16'($sampled(strobes)));
    idle_do_pc: assert property (@(posedge clk) disable iff (rst) chk_idle |-> do_pc == '0)
        else report("do_pc", 16'h0, 16'($sampled(do_pc)));
    short_imm_value: assert property (@(posedge clk) disable iff (rst)
        chk_short |-> short_imm == exp_imm)
        else report("short_imm", 16'(exp_imm), 16'($sampled(short_imm)));
    short_r_value: assert property (@(posedge clk) disable iff (rst)
        chk_short |-> r_field == exp_r)
        else report("r_field", 16'(exp_r), 16'($sampled(r_field)));
    short_no_halt: assert property (@(posedge clk) disable iff (rst) chk_short |-> !pc_halt)
        else report("pc_halt", 16'h0, 16'($sampled(pc_halt)));
    step_value: assert property (@(posedge clk) disable iff (rst)
        chk_step |-> step_sel == exp_step)
        else report("step_sel", 16'(exp_step), 16'($sampled(step_sel)));
    route_value: assert property (@(posedge clk) disable iff (rst)
        chk_route |-> strobes == exp_route)
        else report("load strobes", 16'(exp_route), 16'($sampled(strobes)));
    long_value: assert property (@(posedge clk) disable iff (rst)
        chk_long |-> long_imm == exp_long)
        else report("long_imm", exp_long, $sampled(long_imm));
    jump_ja: assert property (@(posedge clk) disable iff (rst) chk_jump |-> goto_ja == exp_ja)
        else report("goto_ja", 16'(exp_ja), 16'($sampled(goto_ja)));
    jump_b: assert property (@(posedge clk) disable iff (rst) chk_jump |-> goto_b == exp_b)
        else report("goto_b", 16'(exp_b), 16'($sampled(goto_b)));
    irq_start_value: assert property (@(posedge clk) disable iff (rst)
        chk_irq |-> irq_start == exp_irq_start)
        else report("irq_start", 16'(exp_irq_start), 16'($sampled(irq_start)));
    iack_value: assert property (@(posedge clk) disable iff (rst) chk_iack |-> iack == exp_iack)
        else report("iack", 16'(exp_iack), 16'($sampled(iack)));
    fault_clear: assert property (@(posedge clk) disable iff (rst) !fault_ok |-> !fault)
        else report("fault", 16'h0, 16'($sampled(fault)));
    fault_set: assert property (@(posedge clk) disable iff (rst) chk_fault |-> fault)
        else report("fault", 16'h1, 16'($sampled(fault)));
    do_pc_range: assert property (@(posedge clk) disable iff (rst) do_pc < exp_ni)
        else report("do_pc", 16'(exp_ni), 16'($sampled(do_pc)));

    initial begin
        logic [15:0] w;
        logic [15:0] data;
        logic        cond;
        int          ni;
        int          k;
        void'($urandom(78894));
        errors     = 0;
        words      = 0;
        n_out      = 0;
        n_save     = 0;
        fault_ok   = 1'b0;
        exp_ni     = 4'd1;
        clear_checks();
        rst        = 1'b1;
        cen        = 1'b1;
        irq        = 1'b0;
        con_result = 1'b0;
        rom_dout   = filler;
        repeat (8) @(posedge clk);
        #1;
        rst      = 1'b0;
        chk_idle = 1'b1;

        for (int i = 0; i < n_short; i++) begin
            w = {4'b0001, 12'($urandom)};
            send_word(w);
            send_word(filler);
            chk_short = 1'b1;
            chk_route = 1'b1;
            chk_step  = 1'b1;
            exp_imm   = w[8:0];
            exp_r     = w[11:9] ^ 3'b100;
            exp_step  = (w[1:0] == 2'b11);   // ++j pointer mode
            exp_route = 11'b100_0000_0000;
        end

        // Long immediate and RAM loads, the second word must be ignored
        for (int i = 0; i < n_load; i++) begin
            w    = {(i % 2 == 1) ? 5'd15 : 5'd10, 11'($urandom)};
            data = {5'd4, 11'($urandom)};
            send_word(w);
            send_word(data);
            chk_route = 1'b1;
            exp_route = expected_strobes(i % 2 == 1, w[9:7], w[6]);
            chk_long  = (i % 2 == 0);
            exp_long  = data;
            send_word(filler);
            chk_route = 1'b1;
            exp_route = '0;
        end

        for (int i = 0; i < n_jump; i++) begin
            cond = 1'($urandom);
            send_word({5'd26, 1'b0, 10'($urandom)});   // if-prefix
            send_word({4'b0000, 12'($urandom)});
            con_result = cond;
            send_word(bad_word);
            chk_jump = 1'b1;
            exp_ja   = cond;
            exp_b    = 1'b0;
            send_word(filler);
        end
        send_word({4'b0000, 12'($urandom)});
        con_result = 1'b0;
        send_word(bad_word);
        chk_jump = 1'b1;
        exp_ja   = 1'b1;
        exp_b    = 1'b0;
        send_word({5'd26, 11'd0});
        send_word(iret_word);   // Taken even with a false condition
        send_word(bad_word);
        chk_jump = 1'b1;
        exp_ja   = 1'b0;
        exp_b    = 1'b1;
        send_word(filler);

        // Interrupt entry, service with irq held, then iret
        send_word(filler);
        irq = 1'b1;
        send_word(bad_word);
        irq           = 1'b0;
        chk_jump      = 1'b1;
        exp_ja        = 1'b1;
        exp_b         = 1'b0;
        chk_irq       = 1'b1;
        exp_irq_start = 1'b1;
        chk_iack      = 1'b1;
        exp_iack      = 1'b1;
        repeat (3) begin
            send_word(filler);
            irq           = 1'b1;
            chk_irq       = 1'b1;
            exp_irq_start = 1'b0;
            chk_iack      = 1'b1;
            exp_iack      = 1'b1;
        end
        send_word(iret_word);
        irq      = 1'b0;
        chk_iack = 1'b1;
        send_word(bad_word);
        chk_iack = 1'b1;
        chk_jump = 1'b1;
        exp_ja   = 1'b0;
        exp_b    = 1'b1;
        send_word({5'd26, 11'd0});   // Not interruptible, iack holds
        chk_iack = 1'b1;
        send_word(filler);
        chk_iack = 1'b1;
        send_word(filler);
        chk_iack = 1'b1;
        exp_iack = 1'b0;

        ni     = 2 + $urandom % 3;
        k      = 1 + $urandom % 3;
        n_out  = 0;
        n_save = 0;
        send_word({5'd14, 4'(ni), 7'(k)});
        exp_ni = 4'(ni);
        send_word(filler);
        send_word({5'd0, 11'($urandom)});   // Jump inside the loop body
        fault_ok = 1'b1;
        while (n_out == 0)
            send_word(filler);
        repeat (4) send_word(filler);
        chk_fault = 1'b1;
        send_word(filler);
        loop_out_once: assert (n_out == 1)
            else report("do_out pulse count", 16'h1, 16'(n_out));
        loop_save_once: assert (n_save == 1)
            else report("do_save pulse count", 16'h1, 16'(n_save));

        $display("%0d words sent, %0d errors", words, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: hw/dsp_ctrl_top.sv
/* Instruction control unit top level
   Decoder plus DO loop, interrupt and register load routing units */
`timescale 1ns/1ps

module dsp_ctrl_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen,
    input  logic [dsp_ctrl_pkg::insn_w-1:0]  rom_dout,
    input  logic                             irq,
    input  logic                             con_result,
    // Jumps and control
    output logic                             goto_ja,
    output logic                             goto_b,
    output logic                             call_ja,
    output logic                             pc_halt,
    output logic                             con_check,
    output logic                             irq_start,
    output logic                             iack,
    output logic                             fault,
    // Instruction fields
    output logic [dsp_ctrl_pkg::r_w-1:0]     r_field,
    output logic [1:0]                       y_field,
    output logic [dsp_ctrl_pkg::short_imm_w-1:0] short_imm,
    output logic [dsp_ctrl_pkg::insn_w-1:0]  long_imm,
    output logic [1:0]                       inc_sel,
    output logic                             step_sel,
    output logic [1:0]                       a_field,
    output logic                             dau_dec_en,
    output logic                             ram_we,
    output logic                             post_load,
    // Register load strobes
    output logic                             short_load,
    output logic                             long_load,
    output logic                             ram_load,
    output logic                             xaau_imm_load,
    output logic                             xaau_ram_load,
    output logic                             dau_imm_load,
    output logic                             dau_ram_load,
    output logic                             sio_imm_load,
    output logic                             sio_ram_load,
    output logic                             pio_imm_load,
    output logic                             pio_ram_load,
    // DO loop
    output logic                             do_start,
    output logic                             do_out,
    output logic                             do_redo,
    output logic                             do_save,
    output logic                             do_short,
    output logic [dsp_ctrl_pkg::do_ni_w-1:0] do_pc
);
    import dsp_ctrl_pkg::*;

    logic [t_w-1:0]       t_field;
    logic                 stretch;
    load_kind_e           load_kind;
    dest_e                dest;
    logic                 do_load;
    logic [do_data_w-1:0] do_data;
    logic                 do_busy;
    logic                 loop_stall;
    logic                 irq_take;
    logic                 iret_seen;

    assign long_imm = rom_dout; // Valid in the second cycle of a long load

    insn_decoder u_dec (
        .clk(clk), .rst(rst), .cen(cen),
        .rom_dout(rom_dout), .con_result(con_result),
        .do_busy(do_busy), .loop_stall(loop_stall), .irq_take(irq_take),
        .t_field(t_field), .r_field(r_field), .y_field(y_field), .a_field(a_field),
        .short_imm(short_imm), .inc_sel(inc_sel), .step_sel(step_sel),
        .goto_ja(goto_ja), .goto_b(goto_b), .call_ja(call_ja), .pc_halt(pc_halt),
        .con_check(con_check), .irq_start(irq_start), .dau_dec_en(dau_dec_en),
        .ram_we(ram_we), .post_load(post_load), .fault(fault),
        .iret_seen(iret_seen), .stretch(stretch),
        .load_kind(load_kind), .dest(dest),
        .do_load(do_load), .do_data(do_data)
    );

    do_loop_unit u_loop (
        .clk(clk), .rst(rst), .cen(cen),
        .do_load(do_load), .do_data(do_data), .stretch(stretch),
        .do_busy(do_busy), .loop_stall(loop_stall),
        .do_start(do_start), .do_out(do_out), .do_redo(do_redo),
        .do_save(do_save), .do_short(do_short), .do_pc(do_pc)
    );

    irq_unit u_irq (
        .clk(clk), .rst(rst), .cen(cen), .irq(irq),
        .t_field(t_field), .iret_seen(iret_seen),
        .do_busy(do_busy), .stretch(stretch),
        .irq_take(irq_take), .iack(iack)
    );

    load_route u_route (
        .clk(clk), .rst(rst), .cen(cen),
        .load_kind(load_kind), .dest(dest),
        .short_load(short_load), .long_load(long_load), .ram_load(ram_load),
        .xaau_imm_load(xaau_imm_load), .xaau_ram_load(xaau_ram_load),
        .dau_imm_load(dau_imm_load), .dau_ram_load(dau_ram_load),
        .sio_imm_load(sio_imm_load), .sio_ram_load(sio_ram_load),
        .pio_imm_load(pio_imm_load), .pio_ram_load(pio_ram_load)
    );

endmodule

// File: hw/insn_decoder.sv
/* Instruction decoder: T-field decode, two-cycle sequencing,
   jump, RAM and F1 strobes, load routing codes and DO requests */
`timescale 1ns/1ps

module insn_decoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic [dsp_ctrl_pkg::insn_w-1:0]    rom_dout,
    input  logic                               con_result,
    input  logic                               do_busy,
    input  logic                               loop_stall,
    input  logic                               irq_take,
    output logic [dsp_ctrl_pkg::t_w-1:0]       t_field,
    output logic [dsp_ctrl_pkg::r_w-1:0]       r_field,
    output logic [1:0]                         y_field,
    output logic [1:0]                         a_field,
    output logic [dsp_ctrl_pkg::short_imm_w-1:0] short_imm,
    output logic [1:0]                         inc_sel,
    output logic                               step_sel,
    output logic                               goto_ja,
    output logic                               goto_b,
    output logic                               call_ja,
    output logic                               pc_halt,
    output logic                               con_check,
    output logic                               irq_start,
    output logic                               dau_dec_en,
    output logic                               ram_we,
    output logic                               post_load,
    output logic                               fault,
    output logic                               iret_seen,
    output logic                               stretch,
    output dsp_ctrl_pkg::load_kind_e           load_kind,
    output dsp_ctrl_pkg::dest_e                dest,
    output logic                               do_load,
    output logic [dsp_ctrl_pkg::do_data_w-1:0] do_data
);
    import dsp_ctrl_pkg::*;

    cycle_e cyc;
    t_op_e  op;
    dest_e  reg_dest;
    logic   iret;
    logic   con_ok;

    assign t_field = rom_dout[15:11];
    assign stretch = (cyc == cyc_second);
    assign iret    = (rom_dout[10:8] == 3'b001);
    assign con_ok  = !con_check || con_result; // Pending if-prefix gates the jump

    // Goto, short imm and call ignore bit 0 of T
    always_comb begin
        if (t_field[4:1] == 4'b0000 || t_field[4:1] == 4'b0001 || t_field[4:1] == 4'b1000)
            op = t_op_e'({t_field[4:1], 1'b0});
        else
            op = t_op_e'(t_field);
    end

    always_comb begin
        case (rom_dout[9:7])
            3'b000:  reg_dest = dest_yaau;
            3'b001:  reg_dest = dest_xaau;
            3'b010:  reg_dest = dest_dau;
            3'b011:  reg_dest = rom_dout[6] ? dest_pio : dest_sio;
            default: reg_dest = dest_none;
        endcase
    end

    // Short immediate goes out as an immediate with no destination
    always_comb begin
        load_kind = kind_none;
        dest      = dest_none;
        if (!stretch && !irq_take) begin
            case (op)
                op_short_imm: load_kind = kind_imm;
                op_long_imm, op_ram_load: begin
                    if (reg_dest != dest_none) begin
                        load_kind = (op == op_long_imm) ? kind_imm : kind_ram;
                        dest      = reg_dest;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            r_field   <= (op == op_short_imm) ? rom_dout[11:9] ^ 3'b100 : rom_dout[6:4];
            y_field   <= rom_dout[3:2];
            a_field   <= rom_dout[10:9];
            short_imm <= rom_dout[8:0];
            do_data   <= rom_dout[10:0];
            step_sel  <= (rom_dout[1:0] == 2'd3);
            case (rom_dout[1:0])   // Pointer post-modify
                2'd0:    inc_sel <= 2'd1;    // *rN
                2'd1:    inc_sel <= 2'd2;    // *rN++
                default: inc_sel <= 2'd0;    // *rN-- and *rN++j
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc        <= cyc_first;
            goto_ja    <= 1'b0;
            goto_b     <= 1'b0;
            call_ja    <= 1'b0;
            pc_halt    <= 1'b0;
            con_check  <= 1'b0;
            irq_start  <= 1'b0;
            dau_dec_en <= 1'b0;
            ram_we     <= 1'b0;
            post_load  <= 1'b0;
            iret_seen  <= 1'b0;
            do_load    <= 1'b0;
            fault      <= 1'b0;
        end else if (cen) begin
            cyc        <= cyc_first;
            goto_ja    <= 1'b0;
            goto_b     <= 1'b0;
            call_ja    <= 1'b0;
            pc_halt    <= 1'b0;
            con_check  <= 1'b0;
            irq_start  <= 1'b0;
            dau_dec_en <= 1'b0;
            ram_we     <= 1'b0;
            post_load  <= 1'b0;
            iret_seen  <= 1'b0;
            do_load    <= 1'b0;
            if (!stretch) begin
                if (irq_take) begin   // Vector fetch replaces the word
                    goto_ja   <= 1'b1;
                    irq_start <= 1'b1;
                    pc_halt   <= 1'b1;
                    cyc       <= cyc_second;
                end else begin
                    case (op)
                        op_goto_ja, op_call_ja, op_goto_b: begin
                            goto_ja   <= (op == op_goto_ja) && con_ok;
                            call_ja   <= (op == op_call_ja) && con_ok;
                            goto_b    <= (op == op_goto_b) && (con_ok || iret);
                            iret_seen <= (op == op_goto_b) && iret;
                            pc_halt   <= 1'b1;
                            cyc       <= cyc_second;
                            if (do_busy)
                                fault <= 1'b1;   // No jumps inside a loop
                        end
                        op_short_imm: ;          // Handled by load routing
                        op_long_imm:  cyc <= cyc_second;
                        op_ram_load, op_ram_store: begin
                            ram_we    <= (op == op_ram_store);
                            post_load <= 1'b1;
                            pc_halt   <= 1'b1;
                            cyc       <= cyc_second;
                        end
                        op_f1_y, op_f1_at_y, op_f1_x_y, op_f1_load_yk: begin
                            dau_dec_en <= 1'b1;
                            post_load  <= 1'b1;
                        end
                        op_f1_store_y, op_f1_store_a: begin
                            dau_dec_en <= 1'b1;
                            post_load  <= 1'b1;
                            ram_we     <= 1'b1;
                            pc_halt    <= 1'b1;
                            cyc        <= cyc_second;
                        end
                        op_if_con: begin
                            if (!rom_dout[10])
                                con_check <= 1'b1;
                            else
                                fault <= 1'b1;   // icall form
                        end
                        op_do:   do_load <= 1'b1;
                        default: fault   <= 1'b1;
                    endcase
                end
            end
            if (loop_stall) begin   // Loop boundary word takes two cycles
                pc_halt <= 1'b1;
                cyc     <= cyc_second;
            end
        end
    end

    a_halt_single: assert property (@(posedge clk) disable iff (rst)
        (cen && pc_halt) |=> (!pc_halt || $past(loop_stall)))
        else $error("pc_halt held for two cycles outside a loop stall");

endmodule

// File: hw/do_loop_unit.sv
/* DO/REDO zero-overhead loop counters
   Pass and word tracking, loop status and boundary stalls */
`timescale 1ns/1ps

module do_loop_unit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic                               do_load,
    input  logic [dsp_ctrl_pkg::do_data_w-1:0] do_data,
    input  logic                               stretch,
    output logic                               do_busy,
    output logic                               loop_stall,
    output logic                               do_start,
    output logic                               do_out,
    output logic                               do_redo,
    output logic                               do_save,
    output logic                               do_short,
    output logic [dsp_ctrl_pkg::do_ni_w-1:0]   do_pc
);
    import dsp_ctrl_pkg::*;

    logic [do_ni_w-1:0] ni_in;
    logic [do_ni_w-1:0] ni;
    logic [do_ni_w-1:0] ni_cnt;
    logic [do_k_w-1:0]  k_in;
    logic [do_k_w-1:0]  k;
    logic [do_k_w-1:0]  k_cnt;
    logic               one_done;   // First pass already stretched
    logic               over;
    logic               first_loop;

    assign ni_in    = do_data[do_data_w-1 -: do_ni_w];
    assign k_in     = do_data[do_k_w-1:0];
    assign do_short = do_load && (ni_in == 4'd1);
    assign do_save  = do_load && (ni_in != 4'd0);
    assign do_busy  = (k_cnt != '0);
    assign over     = (ni_cnt == ni);   // Last word of a pass
    assign do_pc    = ni_cnt;

    assign first_loop = (over && k_cnt == k && do_busy && !one_done) || do_short;
    assign do_out     = do_busy && over && (k_cnt == 7'd1) && !stretch;
    assign do_start   = first_loop && !do_redo && (k_cnt != 7'd1);
    assign loop_stall = (first_loop && !do_redo) || do_out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ni       <= '0;
            k        <= '0;
            ni_cnt   <= '0;
            k_cnt    <= '0;
            one_done <= 1'b0;
            do_redo  <= 1'b0;
        end else if (cen) begin
            if (do_load) begin
                ni       <= (ni_in == 4'd0) ? '0 : ni_in - 4'd1;
                k        <= do_short ? k_in - 7'd1 : k_in;
                k_cnt    <= do_short ? k_in - 7'd1 : k_in;
                ni_cnt   <= (ni_in <= 4'd1) ? 4'd0 : 4'd1; // First word already fetched
                do_redo  <= (ni_in == 4'd0);
                one_done <= do_short;
            end else begin
                if (!stretch && do_busy) begin
                    ni_cnt <= over ? '0 : ni_cnt + 4'd1;
                    if (over)
                        k_cnt <= k_cnt - 7'd1;
                end
                if (loop_stall)
                    one_done <= 1'b1;
                if (do_out)
                    do_redo <= 1'b0;
            end
        end
    end

    a_start_out: assert property (@(posedge clk) disable iff (rst)
        !(do_start && do_out))
        else $error("do_start and do_out high together");

endmodule

// File: hw/irq_unit.sv
/* Interrupt acceptance and acknowledge tracking */
`timescale 1ns/1ps

module irq_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cen,
    input  logic                         irq,
    input  logic [dsp_ctrl_pkg::t_w-1:0] t_field,
    input  logic                         iret_seen,
    input  logic                         do_busy,
    input  logic                         stretch,
    output logic                         irq_take,
    output logic                         iack
);
    import dsp_ctrl_pkg::*;

    logic irq_ok;
    logic clr_pend;   // iret done, waiting for an interruptible word

    // Jumps, prefixes and DO cannot be split from their successor
    always_comb begin
        case (t_field)
            op_goto_ja, 5'd1, op_do, op_call_ja, 5'd17, op_goto_b, op_if_con:
                irq_ok = 1'b0;
            default:
                irq_ok = 1'b1;
        endcase
    end

    assign irq_take = irq && !do_busy && !stretch && irq_ok && !iack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iack     <= 1'b0;
            clr_pend <= 1'b0;
        end else if (cen) begin
            if (irq_take) begin
                iack     <= 1'b1;
                clr_pend <= 1'b0;
            end else if (iret_seen) begin
                clr_pend <= 1'b1;
            end else if (clr_pend && irq_ok && !stretch) begin
                iack     <= 1'b0;
                clr_pend <= 1'b0;
            end
        end
    end

    a_take_ack: assert property (@(posedge clk) disable iff (rst)
        (cen && irq_take) |-> !iack ##1 iack)
        else $error("interrupt accepted while acknowledge pending");

endmodule

// File: hw/load_route.sv
/* Register load routing
   Destination and load kind to registered one-hot load strobes */
`timescale 1ns/1ps

module load_route (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  dsp_ctrl_pkg::load_kind_e load_kind,
    input  dsp_ctrl_pkg::dest_e      dest,
    output logic                     short_load,
    output logic                     long_load,
    output logic                     ram_load,
    output logic                     xaau_imm_load,
    output logic                     xaau_ram_load,
    output logic                     dau_imm_load,
    output logic                     dau_ram_load,
    output logic                     sio_imm_load,
    output logic                     sio_ram_load,
    output logic                     pio_imm_load,
    output logic                     pio_ram_load
);
    import dsp_ctrl_pkg::*;

    logic is_imm;
    logic is_ram;

    assign is_imm = (load_kind == kind_imm);
    assign is_ram = (load_kind == kind_ram);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            short_load    <= 1'b0;
            long_load     <= 1'b0;
            ram_load      <= 1'b0;
            xaau_imm_load <= 1'b0;
            xaau_ram_load <= 1'b0;
            dau_imm_load  <= 1'b0;
            dau_ram_load  <= 1'b0;
            sio_imm_load  <= 1'b0;
            sio_ram_load  <= 1'b0;
            pio_imm_load  <= 1'b0;
            pio_ram_load  <= 1'b0;
        end else if (cen) begin
            short_load    <= is_imm && (dest == dest_none); // Short form j, k, rb, re
            long_load     <= is_imm && (dest == dest_yaau);
            ram_load      <= is_ram && (dest == dest_yaau);
            xaau_imm_load <= is_imm && (dest == dest_xaau);
            xaau_ram_load <= is_ram && (dest == dest_xaau);
            dau_imm_load  <= is_imm && (dest == dest_dau);
            dau_ram_load  <= is_ram && (dest == dest_dau);
            sio_imm_load  <= is_imm && (dest == dest_sio);
            sio_ram_load  <= is_ram && (dest == dest_sio);
            pio_imm_load  <= is_imm && (dest == dest_pio);
            pio_ram_load  <= is_ram && (dest == dest_pio);
        end
    end

    a_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({short_load, long_load, ram_load, xaau_imm_load, xaau_ram_load,
                  dau_imm_load, dau_ram_load, sio_imm_load, sio_ram_load,
                  pio_imm_load, pio_ram_load}))
        else $error("more than one register load strobe active");

endmodule

// File: hw/dsp_ctrl_pkg.sv
/* Instruction set constants for the DSP control unit:
   field widths, T-field opcodes, decoder cycle state and load routing codes */
package dsp_ctrl_pkg;

    localparam int insn_w      = 16;
    localparam int t_w         = 5;
    localparam int short_imm_w = 9;
    localparam int do_ni_w     = 4;
    localparam int do_k_w      = 7;
    localparam int do_data_w   = 11;
    localparam int r_w         = 3;

    // Paired codes (goto, short imm, call) are listed by their even member
    typedef enum logic [t_w-1:0] {
        op_goto_ja     = 5'd0,
        op_short_imm   = 5'd2,
        op_f1_y        = 5'd6,
        op_f1_at_y     = 5'd7,
        op_long_imm    = 5'd10,
        op_ram_store   = 5'd12,
        op_do          = 5'd14,
        op_ram_load    = 5'd15,
        op_call_ja     = 5'd16,
        op_f1_store_y  = 5'd20,
        op_f1_x_y      = 5'd22,
        op_f1_load_yk  = 5'd23,
        op_goto_b      = 5'd24,
        op_if_con      = 5'd26,
        op_f1_store_a  = 5'd28
    } t_op_e;

    typedef enum logic {
        cyc_first,
        cyc_second
    } cycle_e;

    typedef enum logic [2:0] {
        dest_yaau = 3'd0,
        dest_xaau = 3'd1,
        dest_dau  = 3'd2,
        dest_sio  = 3'd3,
        dest_pio  = 3'd4,
        dest_none = 3'd7
    } dest_e;

    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_imm  = 2'd1,
        kind_ram  = 2'd2
    } load_kind_e;

endpackage
